// File: design/rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// datapath widths
`define XLEN        64
`define ILEN        32

// register file geometry
`define REG_COUNT   32
`define REG_IDX_W   5

// first fetch address after reset
`define RESET_PC    64'h0000_0000_8000_0000

// major opcodes, inst[6:0]
`define OPC_LUI     7'b0110111
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

`endif

// File: design/rv_core_pkg.sv
`include "rv_core_macros.svh"

package rv_core_pkg;

    typedef logic [`XLEN-1:0]      xword_t;
    typedef logic [`ILEN-1:0]      inst_t;
    typedef logic [`XLEN-1:0]      addr_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // write-back source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_LINK
    } wb_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    src_imm;
        logic    rd_en;
        wb_sel_e wb_sel;
        logic    is_load;
        logic    is_store;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jal;
    } inst_ctrl_t;

    // instruction bus request
    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

    // data bus request, always full width
    typedef struct packed {
        addr_t  addr;
        xword_t wdata;
        logic   write;
    } mem_req_t;

endpackage

// File: design/bus_request_hold.sv
`timescale 1ns/10ps

module bus_request_hold
    import rv_core_pkg::*;
#(
    parameter type req_t = fetch_req_t
) (
    input  logic inst_selfdefine,
    input  logic reset,
    input  logic start,
    input  req_t req_in,
    input  logic ready,
    output logic valid,
    output req_t req,
    output logic done
);

    // valid stays up until the memory takes the request
    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (start) begin
            valid <= 1'b1;
        end else if (valid && ready) begin
            valid <= 1'b0;
        end
    end

    // request frozen for the whole transfer
    always_ff @(posedge inst_selfdefine) begin
        if (start) begin
            req <= req_in;
        end
    end

    assign done = valid & ready;

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module fetch_unit
    import rv_core_pkg::*;
(
    input  logic  inst_selfdefine,
    input  logic  reset,
    input  logic  fetch_done,
    input  inst_t if_data_read,
    input  logic  pc_advance,
    input  logic  take_target,
    input  addr_t target,
    output addr_t pc,
    output inst_t inst
);

    addr_t pc_next;

    // taken branch or jump, else sequential
    always_comb begin
        if (take_target) begin
            pc_next = target;
        end else begin
            pc_next = pc + 64'd4;
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (pc_advance) begin
            pc <= pc_next;
        end
    end

    // instruction register, loaded on the fetch handshake
    always_ff @(posedge inst_selfdefine) begin
        if (fetch_done) begin
            inst <= if_data_read;
        end
    end

endmodule

// File: design/inst_decode.sv
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module inst_decode
    import rv_core_pkg::*;
(
    input  inst_t      inst,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output reg_idx_t   rd,
    output xword_t     imm,
    output inst_ctrl_t ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    // immediate format follows the opcode
    always_comb begin
        case (opcode)
            `OPC_OP_IMM, `OPC_LOAD: begin
                imm = {{52{inst[31]}}, inst[31:20]};
            end
            `OPC_STORE: begin
                imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
            end
            `OPC_BRANCH: begin
                imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            `OPC_LUI: begin
                imm = {{32{inst[31]}}, inst[31:12], 12'b0};
            end
            `OPC_JAL: begin
                imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    // unsupported encodings fall through as a no-op
    always_comb begin
        ctrl = '0;
        case (opcode)
            `OPC_LUI: begin
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.src_imm = 1'b1;
                ctrl.rd_en   = 1'b1;
            end
            `OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin
                    ctrl.alu_op  = ALU_ADD;
                    ctrl.src_imm = 1'b1;
                    ctrl.rd_en   = 1'b1;
                end
            end
            `OPC_OP: begin
                ctrl.rd_en = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: ctrl.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: ctrl.alu_op = ALU_XOR;
                    default:              ctrl.rd_en  = 1'b0;
                endcase
            end
            `OPC_LOAD: begin
                if (funct3 == 3'b011) begin
                    ctrl.alu_op  = ALU_ADD;
                    ctrl.src_imm = 1'b1;
                    ctrl.rd_en   = 1'b1;
                    ctrl.wb_sel  = WB_LOAD;
                    ctrl.is_load = 1'b1;
                end
            end
            `OPC_STORE: begin
                if (funct3 == 3'b011) begin
                    ctrl.alu_op   = ALU_ADD;
                    ctrl.src_imm  = 1'b1;
                    ctrl.is_store = 1'b1;
                end
            end
            `OPC_BRANCH: begin
                // beq and bne only
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    ctrl.is_branch = 1'b1;
                    ctrl.branch_ne = funct3[0];
                end
            end
            `OPC_JAL: begin
                ctrl.rd_en  = 1'b1;
                ctrl.wb_sel = WB_LINK;
                ctrl.is_jal = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: design/exec_alu.sv
`timescale 1ns/10ps

module exec_alu
    import rv_core_pkg::*;
(
    input  inst_ctrl_t ctrl,
    input  addr_t      pc,
    input  xword_t     rs1_data,
    input  xword_t     rs2_data,
    input  xword_t     imm,
    output xword_t     result,
    output addr_t      target,
    output logic       take_target
);

    xword_t operand_b;
    logic   rs_equal;

    assign operand_b = ctrl.src_imm ? imm : rs2_data;

    // also produces the load/store address
    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    result = rs1_data + operand_b;
            ALU_SUB:    result = rs1_data - operand_b;
            ALU_AND:    result = rs1_data & operand_b;
            ALU_OR:     result = rs1_data | operand_b;
            ALU_XOR:    result = rs1_data ^ operand_b;
            ALU_PASS_B: result = operand_b;
            default:    result = '0;
        endcase
    end

    // pc-relative target shared by branches and jal
    assign target = pc + imm;

    assign rs_equal = (rs1_data == rs2_data);

    always_comb begin
        take_target = 1'b0;
        if (ctrl.is_jal) begin
            take_target = 1'b1;
        end else if (ctrl.is_branch) begin
            take_target = rs_equal ^ ctrl.branch_ne;
        end
    end

endmodule

// File: design/regfile.sv
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module regfile
    import rv_core_pkg::*;
(
    input  logic     inst_selfdefine,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     rd_we,
    input  xword_t   rd_data,
    output xword_t   rs1_data,
    output xword_t   rs2_data
);

    xword_t regs [`REG_COUNT];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: design/load_store_unit.sv
`timescale 1ns/10ps

module load_store_unit
    import rv_core_pkg::*;
(
    input  logic     inst_selfdefine,
    input  logic     reset,
    input  addr_t    addr,
    input  xword_t   store_data,
    input  logic     is_store,
    input  logic     mem_done,
    input  xword_t   mem_data_read,
    output mem_req_t mem_req_next,
    output xword_t   load_data
);

    xword_t load_q;

    assign mem_req_next.addr  = addr;
    assign mem_req_next.wdata = store_data;
    assign mem_req_next.write = is_store;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            load_q <= '0;
        end else if (mem_done) begin
            load_q <= mem_data_read;
        end
    end

    // bus data on the handshake so the write lands on that edge,
    // held value afterwards
    assign load_data = mem_done ? mem_data_read : load_q;

endmodule

// File: design/rv_core.sv
`timescale 1ns/10ps

module rv_core
    import rv_core_pkg::*;
(
    input  logic       inst_selfdefine,
    input  logic       reset,

    output logic       if_valid,
    output fetch_req_t if_req,
    input  logic       if_ready,
    input  inst_t      if_data_read,

    output logic       mem_valid,
    output mem_req_t   mem_req,
    input  logic       mem_ready,
    input  xword_t     mem_data_read
);

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_MEM
    } seq_state_e;

    seq_state_e state;
    logic       fetch_start;
    logic       mem_start;
    logic       if_done;
    logic       mem_done;
    logic       is_mem;
    logic       pc_advance;
    logic       rd_we;

    fetch_req_t fetch_req_in;
    mem_req_t   mem_req_next;

    addr_t      pc;
    inst_t      inst;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    xword_t     imm;
    inst_ctrl_t ctrl;
    xword_t     rs1_data;
    xword_t     rs2_data;
    xword_t     result;
    addr_t      target;
    logic       take_target;
    xword_t     load_data;
    xword_t     rd_data;

    assign is_mem = ctrl.is_load | ctrl.is_store;

    // one instruction in flight, fetch -> exec -> (mem)
    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state       <= S_FETCH;
            fetch_start <= 1'b1;
        end else begin
            fetch_start <= 1'b0;
            case (state)
                S_FETCH: begin
                    if (if_done) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (is_mem) begin
                        state <= S_MEM;
                    end else begin
                        state       <= S_FETCH;
                        fetch_start <= 1'b1;
                    end
                end
                S_MEM: begin
                    if (mem_done) begin
                        state       <= S_FETCH;
                        fetch_start <= 1'b1;
                    end
                end
                default: begin
                    state <= S_FETCH;
                end
            endcase
        end
    end

    assign mem_start  = (state == S_EXEC) && is_mem;
    assign pc_advance = ((state == S_EXEC) && !is_mem) || ((state == S_MEM) && mem_done);

    // stores never set rd_en, loads only retire in MEM
    assign rd_we = ctrl.rd_en & pc_advance;

    always_comb begin
        case (ctrl.wb_sel)
            WB_LOAD: rd_data = load_data;
            WB_LINK: rd_data = pc + 64'd4;
            default: rd_data = result;
        endcase
    end

    assign fetch_req_in.addr = pc;

    bus_request_hold #(
        .req_t(fetch_req_t)
    ) i_fetch_hold (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .start          (fetch_start),
        .req_in         (fetch_req_in),
        .ready          (if_ready),
        .valid          (if_valid),
        .req            (if_req),
        .done           (if_done)
    );

    bus_request_hold #(
        .req_t(mem_req_t)
    ) i_mem_hold (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .start          (mem_start),
        .req_in         (mem_req_next),
        .ready          (mem_ready),
        .valid          (mem_valid),
        .req            (mem_req),
        .done           (mem_done)
    );

    fetch_unit i_fetch_unit (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .fetch_done     (if_done),
        .if_data_read   (if_data_read),
        .pc_advance     (pc_advance),
        .take_target    (take_target),
        .target         (target),
        .pc             (pc),
        .inst           (inst)
    );

    inst_decode i_inst_decode (
        .inst(inst),
        .rs1 (rs1),
        .rs2 (rs2),
        .rd  (rd),
        .imm (imm),
        .ctrl(ctrl)
    );

    exec_alu i_exec_alu (
        .ctrl       (ctrl),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .result     (result),
        .target     (target),
        .take_target(take_target)
    );

    regfile i_regfile (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd             (rd),
        .rd_we          (rd_we),
        .rd_data        (rd_data),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data)
    );

    load_store_unit i_load_store_unit (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .addr           (result),
        .store_data     (rs2_data),
        .is_store       (ctrl.is_store),
        .mem_done       (mem_done),
        .mem_data_read  (mem_data_read),
        .mem_req_next   (mem_req_next),
        .load_data      (load_data)
    );

endmodule

// File: verification/tb_rv_core.sv
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module tb_rv_core
    import rv_core_pkg::*;
();

    logic       inst_selfdefine;
    logic       reset;
    logic       if_valid;
    fetch_req_t if_req;
    logic       if_ready;
    inst_t      if_data_read;
    logic       mem_valid;
    mem_req_t   mem_req;
    logic       mem_ready;
    xword_t     mem_data_read;

    inst_t      imem [addr_t];
    xword_t     dmem [addr_t];
    addr_t      exp_fetch [$];
    mem_req_t   exp_store [$];

    integer     seed = 49982;
    integer     value_errors = 0;
    integer     bus_errors = 0;
    integer     timeout_errors = 0;
    integer     file_errors = 0;

    // a negative wait count marks an idle bus model
    integer     if_wait = -1;
    integer     fetch_count = 0;
    logic       if_after = 1'b0;
    fetch_req_t if_held;
    inst_t      if_word;
    integer     mem_wait = -1;
    logic       mem_after = 1'b0;
    mem_req_t   mem_held;

    integer     cycles;
    logic       timed_out;

    rv_core i_rv_core (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .if_valid       (if_valid),
        .if_req         (if_req),
        .if_ready       (if_ready),
        .if_data_read   (if_data_read),
        .mem_valid      (mem_valid),
        .mem_req        (mem_req),
        .mem_ready      (mem_ready),
        .mem_data_read  (mem_data_read)
    );

    always #50 inst_selfdefine = ~inst_selfdefine;

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_store(input string name, input mem_req_t expected,
                               input mem_req_t actual);
        if (actual !== expected) begin
            $display("FAIL %0t %s expected addr %h data %h write %b got addr %h data %h write %b",
                     $time, name, expected.addr, expected.wdata, expected.write,
                     actual.addr, actual.wdata, actual.write);
            value_errors++;
        end
    endtask

    task automatic check_inst(input string name, input inst_t expected, input inst_t actual);
        if (actual !== expected) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %0t %s expected %b got %b", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic load_program();
        integer           fd;
        integer           n;
        logic             done;
        logic [7:0]       tag;
        logic [8*120-1:0] rest;
        addr_t            a;
        xword_t           v;
        inst_t            w;
        mem_req_t         s;
        done = 1'b0;
        fd = $fopen("verification/program_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the program file verification/program_input.txt");
            file_errors++;
        end else begin
            while (!done) begin
                n = $fscanf(fd, "%s", tag);
                if (n != 1) begin
                    done = 1'b1;
                end else if (tag == "#") begin
                    n = $fgets(rest, fd);
                end else if (tag == "I") begin
                    n = $fscanf(fd, "%h %h", a, w);
                    imem[a] = w;
                end else if (tag == "D") begin
                    n = $fscanf(fd, "%h %h", a, v);
                    dmem[a] = v;
                end else if (tag == "F") begin
                    n = $fscanf(fd, "%h", a);
                    exp_fetch.push_back(a);
                end else if (tag == "S") begin
                    n = $fscanf(fd, "%h %h", a, v);
                    s.addr  = a;
                    s.wdata = v;
                    s.write = 1'b1;
                    exp_store.push_back(s);
                end else begin
                    $display("unknown line tag %s in the program file", tag);
                    file_errors++;
                    done = 1'b1;
                end
            end
            $fclose(fd);
        end
    endtask

    // instruction memory answers after 0 to 3 wait cycles
    always @(posedge inst_selfdefine) begin
        if (reset) begin
            if_ready <= 1'b0;
            if_wait = -1;
            if_after = 1'b0;
        end else if (if_valid && if_ready) begin
            if (fetch_count == 0) begin
                check_addr("first if_req.addr", `RESET_PC, if_req.addr);
            end
            if (exp_fetch.size() == 0) begin
                $display("fetch from %h at %0t goes past the expected fetch list", if_req.addr,
                         $time);
                bus_errors++;
            end else begin
                check_addr("if_req.addr", exp_fetch.pop_front(), if_req.addr);
            end
            fetch_count++;
            if_ready <= 1'b0;
            if_wait = -1;
            if_after = 1'b1;
        end else begin
            if (if_after) begin
                check_bit("if_valid", 1'b0, if_valid);
                check_inst("instruction register", if_word, i_rv_core.inst);
                if_after = 1'b0;
            end
            if (if_valid) begin
                if (if_wait < 0) begin
                    if_held = if_req;
                    if_wait = $unsigned($random(seed)) % 4;
                end else begin
                    check_addr("if_req.addr held", if_held.addr, if_req.addr);
                end
                if (if_wait == 0) begin
                    if (imem.exists(if_req.addr)) begin
                        if_word = imem[if_req.addr];
                    end else begin
                        $display("fetch from %h at %0t hits no program word", if_req.addr,
                                 $time);
                        bus_errors++;
                        if_word = '0;
                    end
                    if_ready <= 1'b1;
                    if_data_read <= if_word;
                end else begin
                    if_wait--;
                end
            end else if (if_wait >= 0) begin
                $display("if_valid dropped at %0t before the fetch was accepted", $time);
                bus_errors++;
                if_wait = -1;
            end
        end
    end

    // data memory
    always @(posedge inst_selfdefine) begin
        if (reset) begin
            mem_ready <= 1'b0;
            mem_wait = -1;
            mem_after = 1'b0;
        end else if (mem_valid && mem_ready) begin
            if (mem_req.write) begin
                if (exp_store.size() == 0) begin
                    $display("store to %h at %0t was not expected", mem_req.addr, $time);
                    bus_errors++;
                end else begin
                    check_store("mem_req", exp_store.pop_front(), mem_req);
                end
                dmem[mem_req.addr] = mem_req.wdata;
            end
            mem_ready <= 1'b0;
            mem_wait = -1;
            mem_after = 1'b1;
        end else begin
            if (mem_after) begin
                check_bit("mem_valid", 1'b0, mem_valid);
                mem_after = 1'b0;
            end
            if (mem_valid) begin
                if (mem_wait < 0) begin
                    mem_held = mem_req;
                    mem_wait = $unsigned($random(seed)) % 4;
                end else begin
                    check_store("mem_req held", mem_held, mem_req);
                end
                if (mem_wait == 0) begin
                    // unwritten words read back an address-derived pattern
                    if (dmem.exists(mem_req.addr)) begin
                        mem_data_read <= dmem[mem_req.addr];
                    end else begin
                        mem_data_read <= mem_req.addr ^ 64'hA5A5_5A5A_C3C3_3C3C;
                    end
                    mem_ready <= 1'b1;
                end else begin
                    mem_wait--;
                end
            end else if (mem_wait >= 0) begin
                $display("mem_valid dropped at %0t before the access was accepted", $time);
                bus_errors++;
                mem_wait = -1;
            end
        end
    end

    initial begin
        inst_selfdefine = 1'b0;
        reset <= 1'b1;
        if_ready <= 1'b0;
        if_data_read <= '0;
        mem_ready <= 1'b0;
        mem_data_read <= '0;
        timed_out = 1'b0;
        load_program();

        // reset is released on the tenth rising edge
        repeat (9) begin
            @(negedge inst_selfdefine);
            check_bit("if_valid", 1'b0, if_valid);
            check_bit("mem_valid", 1'b0, mem_valid);
        end
        @(posedge inst_selfdefine);
        reset <= 1'b0;

        // first request within two cycles of reset release
        cycles = 0;
        while (!if_valid && cycles < 2) begin
            @(negedge inst_selfdefine);
            check_bit("mem_valid", 1'b0, mem_valid);
            cycles++;
        end
        if (!if_valid) begin
            $display("timeout: no fetch request within two cycles after reset");
            timeout_errors++;
            timed_out = 1'b1;
        end

        if (!timed_out) begin
            cycles = 0;
            while ((exp_fetch.size() != 0 || exp_store.size() != 0) && cycles < 2000) begin
                @(negedge inst_selfdefine);
                cycles++;
            end
            if (exp_fetch.size() != 0 || exp_store.size() != 0) begin
                $display("timeout: program stalled with %0d fetches and %0d stores outstanding",
                         exp_fetch.size(), exp_store.size());
                timeout_errors++;
            end
        end

        $display("errors: value %0d, bus %0d, timeout %0d, file %0d",
                 value_errors, bus_errors, timeout_errors, file_errors);
        if (value_errors + bus_errors + timeout_errors + file_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verification/program_input.txt
# I addr word, D addr data, F expected fetch addr, S expected store addr data
# F and S lines are checked in the order given
# lui, addi, add, sub, and, or, xor, then two sd
I 80000000 123450b7
I 80000004 67808093
I 80000008 fff00113
I 8000000c 002081b3
I 80000010 40100233
I 80000014 0040f2b3
I 80000018 0051e333
I 8000001c 004343b3
I 80000020 40403023
I 80000024 40703423
# ld, unknown opcode with rd x8, sd of the loaded value
I 80000028 10003403
I 8000002c 0000040b
I 80000030 40803823
# beq not taken, bne taken, beq taken, bne not taken, jal x9, sd x9
I 80000034 00308463
I 80000038 00309463
I 80000040 00210463
I 80000048 00529463
I 8000004c 008004ef
I 80000054 40903c23
# addi to x0, sd x0, jal to itself
I 80000058 00500013
I 8000005c 42003023
I 80000060 0000006f
D 00000100 cafef00ddeadbeef
F 80000000
F 80000004
F 80000008
F 8000000c
F 80000010
F 80000014
F 80000018
F 8000001c
F 80000020
F 80000024
F 80000028
F 8000002c
F 80000030
F 80000034
F 80000038
F 80000040
F 80000048
F 8000004c
F 80000054
F 80000058
F 8000005c
F 80000060
F 80000060
S 00000400 ffffffffedcba988
S 00000408 fffffffffffffff7
S 00000410 cafef00ddeadbeef
S 00000418 0000000080000050
S 00000420 0000000000000000

// File: rv_core.f
+incdir+design
design/rv_core_pkg.sv
design/bus_request_hold.sv
design/fetch_unit.sv
design/inst_decode.sv
design/exec_alu.sv
design/regfile.sv
design/load_store_unit.sv
design/rv_core.sv
verification/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/10ps --top-module tb_rv_core -f rv_core.f

sim_output=$(./obj_dir/Vtb_rv_core)
echo "$sim_output"

echo "$sim_output" | grep -q "^Test OK$"
